/* tb.f */
hw/wb_axi_pkg.sv
hw/wb_to_axil.sv
hw/axil_to_axi.sv
hw/axi_sram.sv
hw/wb_axi_bridge.sv
tests/tb_clock_gen.sv
tests/wb_axi_bridge_assertions.sv
tests/tb_wb_axi_bridge.sv

/* Bender.yml */
package:
  name: wb_axi_bridge

sources:
  - files:
      - hw/wb_axi_pkg.sv
      - hw/wb_to_axil.sv
      - hw/axil_to_axi.sv
      - hw/axi_sram.sv
      - hw/wb_axi_bridge.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/wb_axi_bridge_assertions.sv
      - tests/tb_wb_axi_bridge.sv

/* tests/tb_wb_axi_bridge.sv */
// Directed testbench for the Wishbone to AXI bridge, run as the simulation top module
`timescale 1ns/100ps

module tb_wb_axi_bridge;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int ID_WIDTH   = 4;
	localparam int LGMEM      = 8;
	localparam int LGFIFO     = 3;
	localparam int WB_AW      = ADDR_WIDTH - 2;
	localparam int MEM_WORDS  = 1 << LGMEM;
	localparam int PERIOD_NS  = 40;
	// Fill, single, partial, out of range, pipelined, direction switch
	localparam int TOTAL_REQUESTS = MEM_WORDS + 2 + 18 + 5 + 32 + 16;
	localparam int WATCHDOG_NS    = (TOTAL_REQUESTS * 20 + 500) * PERIOD_NS;
	// Cycles allowed for one burst to drain
	localparam int DRAIN_LIMIT    = 200;

	logic                  clk;
	logic                  rst;
	logic                  i_wb_cyc;
	logic                  i_wb_stb;
	logic                  i_wb_we;
	logic [WB_AW-1:0]      i_wb_addr;
	logic [DATA_WIDTH-1:0] i_wb_data;
	logic [3:0]            i_wb_sel;
	logic                  o_wb_stall;
	logic                  o_wb_ack;
	logic                  o_wb_err;
	logic [DATA_WIDTH-1:0] o_wb_data;

	int          errors = 0;
	int          checks = 0;
	int          assert_failures;
	logic [31:0] lfsr;
	logic [31:0] ref_mem [0:MEM_WORDS-1];
	// Expected responses with the oldest first
	logic        exp_err_q [$];
	logic        exp_read_q [$];
	logic [31:0] exp_data_q [$];
	logic        mon_err;
	logic        mon_read;
	logic [31:0] mon_data;

	tb_clock_gen #(
		.PERIOD_NS   (PERIOD_NS),
		.RESET_CYCLES(4)
	) u_clock (
		.o_clk  (clk),
		.o_reset(rst)
	);

	wb_axi_bridge #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.ID_WIDTH  (ID_WIDTH),
		.LGMEM     (LGMEM),
		.LGFIFO    (LGFIFO)
	) u_dut (
		.i_clk     (clk),
		.i_reset   (rst),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_addr (i_wb_addr),
		.i_wb_data (i_wb_data),
		.i_wb_sel  (i_wb_sel),
		.o_wb_stall(o_wb_stall),
		.o_wb_ack  (o_wb_ack),
		.o_wb_err  (o_wb_err),
		.o_wb_data (o_wb_data)
	);

	////////////////////
	// Helpers
	////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int k = 0; k < n; k++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Initial memory contents where every address bit shows up somewhere
	function automatic logic [31:0] fill_word(input logic [LGMEM-1:0] a);
		return {8'ha5 ^ a, a, ~a, 8'h3c + a};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// Hold one request until accepted, then record what must come back
	task automatic send(input logic we, input logic [WB_AW-1:0] addr,
		input logic [31:0] data, input logic [3:0] sel);
		logic in_range;
		i_wb_cyc  <= 1'b1;
		i_wb_stb  <= 1'b1;
		i_wb_we   <= we;
		i_wb_addr <= addr;
		i_wb_data <= data;
		i_wb_sel  <= sel;
		// Stall settles mid-cycle and holds until the edge that takes the request
		@(negedge clk);
		while (o_wb_stall)
			@(negedge clk);
		@(posedge clk);
		in_range = (addr < MEM_WORDS);
		if (in_range && we)
			for (int b = 0; b < 4; b++)
				if (sel[b])
					ref_mem[addr[LGMEM-1:0]][b*8 +: 8] = data[b*8 +: 8];
		exp_err_q.push_back(!in_range);
		exp_read_q.push_back(!we);
		exp_data_q.push_back(in_range ? ref_mem[addr[LGMEM-1:0]] : 32'h0);
	endtask

	// Drop strobe and wait for every outstanding response
	task automatic finish_burst();
		int waited;
		waited = 0;
		i_wb_stb <= 1'b0;
		@(negedge clk);
		while (exp_err_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		assert (exp_err_q.size() == 0)
		else
		begin
			errors++;
			$display("Responses missing after %0d cycles, %0d still outstanding",
				waited, exp_err_q.size());
			exp_err_q.delete();
			exp_read_q.delete();
			exp_data_q.delete();
		end
		@(posedge clk);
		i_wb_cyc <= 1'b0;
	endtask

	// Response checker working in request order, sampled mid-cycle
	always @(negedge clk)
		if (!rst && (o_wb_ack || o_wb_err))
		begin
			assert (exp_err_q.size() != 0)
			else
			begin
				errors++;
				$display("Response at %0t with no request outstanding", $time);
			end
			if (exp_err_q.size() != 0)
			begin
				mon_err  = exp_err_q.pop_front();
				mon_read = exp_read_q.pop_front();
				mon_data = exp_data_q.pop_front();
				check_value("o_wb_err", 32'(o_wb_err), 32'(mon_err));
				check_value("o_wb_ack", 32'(o_wb_ack), 32'(!mon_err));
				if (mon_read && !mon_err)
					check_value("o_wb_data", o_wb_data, mon_data);
			end
		end

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset_state();
		@(negedge clk);
		check_value("o_wb_stall", 32'(o_wb_stall), 32'h0);
		check_value("o_wb_ack", 32'(o_wb_ack), 32'h0);
		check_value("o_wb_err", 32'(o_wb_err), 32'h0);
		@(posedge clk);
	endtask

	// Known contents everywhere so reads never see X
	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			send(1'b1, WB_AW'(i), fill_word(LGMEM'(i)), 4'hf);
		finish_burst();
	endtask

	task automatic test_write_read();
		send(1'b1, WB_AW'('h17), 32'hdead_beef, 4'hf);
		finish_burst();
		send(1'b0, WB_AW'('h17), 32'h0, 4'hf);
		finish_burst();
	endtask

	task automatic test_partial_writes();
		logic [3:0] sels [9];
		sels = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100,
			4'b0101, 4'b1010, 4'b0000};
		for (int i = 0; i < 9; i++)
			send(1'b1, WB_AW'('h40 + i), take_bits(32), sels[i]);
		finish_burst();
		for (int i = 0; i < 9; i++)
			send(1'b0, WB_AW'('h40 + i), 32'h0, 4'hf);
		finish_burst();
	endtask

	// Word 5 aliases the first bad write if decode were wrong
	task automatic test_out_of_range();
		send(1'b1, WB_AW'(MEM_WORDS + 5), 32'h1234_5678, 4'hf);
		send(1'b1, WB_AW'(4 * MEM_WORDS - 1), 32'h8765_4321, 4'hf);
		send(1'b0, WB_AW'(MEM_WORDS), 32'h0, 4'hf);
		send(1'b0, '1, 32'h0, 4'hf);
		finish_burst();
		send(1'b0, WB_AW'(5), 32'h0, 4'hf);
		finish_burst();
	endtask

	task automatic test_pipelined();
		logic [WB_AW-1:0] addrs [16];
		for (int i = 0; i < 16; i++)
		begin
			addrs[i] = WB_AW'(take_bits(LGMEM));
			send(1'b1, addrs[i], take_bits(32), 4'hf);
		end
		finish_burst();
		for (int i = 0; i < 16; i++)
			send(1'b0, addrs[i], 32'h0, 4'hf);
		finish_burst();
	endtask

	// Reads follow straight on, so they wait out the writes
	task automatic test_direction_switch();
		logic [WB_AW-1:0] addrs [8];
		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = WB_AW'(take_bits(LGMEM));
			send(1'b1, addrs[i], take_bits(32), 4'(take_bits(4)));
		end
		for (int i = 0; i < 8; i++)
			send(1'b0, addrs[i], 32'h0, 4'hf);
		finish_burst();
	endtask

	////////////////////
	// Run control
	////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_wb_sel  = '0;
		lfsr      = 32'hf997_a89e;
		@(posedge clk);
		while (rst)
			@(posedge clk);
		test_reset_state();
		fill_memory();
		test_write_read();
		test_partial_writes();
		test_out_of_range();
		test_pipelined();
		test_direction_switch();
		repeat (4)
			@(posedge clk);
		assert_failures = u_dut.u_ctrl.u_assertions.failures;
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_failures);
		if (errors == 0 && assert_failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* tests/wb_axi_bridge_assertions.sv */
// Concurrent protocol checks on the Wishbone to AXI-lite control block, attached by bind
`timescale 1ns/100ps

module wb_axi_bridge_assertions #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int LGFIFO     = 3
) (
	input logic                  i_clk,
	input logic                  i_reset,
	input logic                  i_awvalid,
	input logic                  i_awready,
	input logic [ADDR_WIDTH-1:0] i_awaddr,
	input logic                  i_wvalid,
	input logic                  i_wready,
	input logic [DATA_WIDTH-1:0] i_wdata,
	input logic                  i_arvalid,
	input logic                  i_arready,
	input logic [ADDR_WIDTH-1:0] i_araddr,
	input logic                  i_wb_ack,
	input logic                  i_wb_err,
	input logic [LGFIFO:0]       i_npending
);

	// Failed assertions so far, summed into the testbench verdict
	int failures = 0;

	////////////////////
	// Request channels
	////////////////////

	// A valid not yet taken stays up with the same payload on the next cycle
	a_aw_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
		else
		begin
			failures++;
			$error("AW valid or address changed before ready");
		end

	a_w_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata))
		else
		begin
			failures++;
			$error("W valid or data changed before ready");
		end

	a_ar_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
		else
		begin
			failures++;
			$error("AR valid or address changed before ready");
		end

	////////////////////
	// Wishbone return
	////////////////////

	// One response kind per cycle
	a_ack_err: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_wb_ack && i_wb_err))
		else
		begin
			failures++;
			$error("Ack and err high together");
		end

	// Outstanding count bounded by the configured depth
	a_count: assert property (@(posedge i_clk) disable iff (i_reset)
		i_npending <= (LGFIFO+1)'(1 << LGFIFO))
		else
		begin
			failures++;
			$error("Outstanding count above its limit");
		end

endmodule

// Attached to every control block instance
bind wb_to_axil wb_axi_bridge_assertions #(
	.ADDR_WIDTH(ADDR_WIDTH),
	.DATA_WIDTH(DATA_WIDTH),
	.LGFIFO    (LGFIFO)
) u_assertions (
	.i_clk     (i_clk),
	.i_reset   (i_reset),
	.i_awvalid (o_awvalid),
	.i_awready (i_awready),
	.i_awaddr  (o_awaddr),
	.i_wvalid  (o_wvalid),
	.i_wready  (i_wready),
	.i_wdata   (o_wdata),
	.i_arvalid (o_arvalid),
	.i_arready (i_arready),
	.i_araddr  (o_araddr),
	.i_wb_ack  (o_wb_ack),
	.i_wb_err  (o_wb_err),
	.i_npending(npending)
);

/* tests/tb_clock_gen.sv */
// Testbench clock and reset source, instantiated once by the bridge testbench
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);

	// Free-running clock, low at time zero
	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset held high for the first few rising edges
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

/* hw/wb_axi_bridge.sv */
// Top level joining Wishbone control, AXI-lite to AXI adapter and AXI memory
`timescale 1ns/100ps

module wb_axi_bridge #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4,
	parameter int LGMEM      = 8,
	parameter int LGFIFO     = 3
) (
	input  logic                                     i_clk,
	input  logic                                     i_reset,
	input  logic                                     i_wb_cyc,
	input  logic                                     i_wb_stb,
	input  logic                                     i_wb_we,
	input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] i_wb_addr,
	input  logic [DATA_WIDTH-1:0]                    i_wb_data,
	input  logic [DATA_WIDTH/8-1:0]                  i_wb_sel,
	output logic                                     o_wb_stall,
	output logic                                     o_wb_ack,
	output logic                                     o_wb_err,
	output logic [DATA_WIDTH-1:0]                    o_wb_data
);

	////////////////////
	// AXI-lite, control to adapter
	////////////////////

	logic                    l_awvalid;
	logic                    l_awready;
	logic [ADDR_WIDTH-1:0]   l_awaddr;
	logic                    l_wvalid;
	logic                    l_wready;
	logic [DATA_WIDTH-1:0]   l_wdata;
	logic [DATA_WIDTH/8-1:0] l_wstrb;
	logic                    l_bvalid;
	logic                    l_bready;
	logic [1:0]              l_bresp;
	logic                    l_arvalid;
	logic                    l_arready;
	logic [ADDR_WIDTH-1:0]   l_araddr;
	logic                    l_rvalid;
	logic                    l_rready;
	logic [DATA_WIDTH-1:0]   l_rdata;
	logic [1:0]              l_rresp;

	////////////////////
	// Full AXI, adapter to memory
	////////////////////

	logic                    m_awvalid;
	logic                    m_awready;
	logic [ID_WIDTH-1:0]     m_awid;
	logic [ADDR_WIDTH-1:0]   m_awaddr;
	logic [7:0]              m_awlen;
	logic [2:0]              m_awsize;
	logic [1:0]              m_awburst;
	logic                    m_wvalid;
	logic                    m_wready;
	logic [DATA_WIDTH-1:0]   m_wdata;
	logic [DATA_WIDTH/8-1:0] m_wstrb;
	logic                    m_wlast;
	logic                    m_bvalid;
	logic                    m_bready;
	logic [1:0]              m_bresp;
	logic                    m_arvalid;
	logic                    m_arready;
	logic [ID_WIDTH-1:0]     m_arid;
	logic [ADDR_WIDTH-1:0]   m_araddr;
	logic [7:0]              m_arlen;
	logic [2:0]              m_arsize;
	logic [1:0]              m_arburst;
	logic                    m_rvalid;
	logic                    m_rready;
	logic [DATA_WIDTH-1:0]   m_rdata;
	logic [1:0]              m_rresp;

	// Wishbone in, AXI-lite out
	wb_to_axil #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.LGFIFO    (LGFIFO)
	) u_ctrl (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_addr (i_wb_addr),
		.i_wb_data (i_wb_data),
		.i_wb_sel  (i_wb_sel),
		.o_wb_stall(o_wb_stall),
		.o_wb_ack  (o_wb_ack),
		.o_wb_err  (o_wb_err),
		.o_wb_data (o_wb_data),
		.o_awvalid (l_awvalid),
		.i_awready (l_awready),
		.o_awaddr  (l_awaddr),
		.o_wvalid  (l_wvalid),
		.i_wready  (l_wready),
		.o_wdata   (l_wdata),
		.o_wstrb   (l_wstrb),
		.i_bvalid  (l_bvalid),
		.o_bready  (l_bready),
		.i_bresp   (l_bresp),
		.o_arvalid (l_arvalid),
		.i_arready (l_arready),
		.o_araddr  (l_araddr),
		.i_rvalid  (l_rvalid),
		.o_rready  (l_rready),
		.i_rdata   (l_rdata),
		.i_rresp   (l_rresp)
	);

	// Slices the requests and fills in the burst fields
	axil_to_axi #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.ID_WIDTH  (ID_WIDTH)
	) u_adapter (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_awvalid  (l_awvalid),
		.o_awready  (l_awready),
		.i_awaddr   (l_awaddr),
		.i_wvalid   (l_wvalid),
		.o_wready   (l_wready),
		.i_wdata    (l_wdata),
		.i_wstrb    (l_wstrb),
		.i_arvalid  (l_arvalid),
		.o_arready  (l_arready),
		.i_araddr   (l_araddr),
		.o_m_awvalid(m_awvalid),
		.i_m_awready(m_awready),
		.o_m_awid   (m_awid),
		.o_m_awaddr (m_awaddr),
		.o_m_awlen  (m_awlen),
		.o_m_awsize (m_awsize),
		.o_m_awburst(m_awburst),
		.o_m_wvalid (m_wvalid),
		.i_m_wready (m_wready),
		.o_m_wdata  (m_wdata),
		.o_m_wstrb  (m_wstrb),
		.o_m_wlast  (m_wlast),
		.o_m_arvalid(m_arvalid),
		.i_m_arready(m_arready),
		.o_m_arid   (m_arid),
		.o_m_araddr (m_araddr),
		.o_m_arlen  (m_arlen),
		.o_m_arsize (m_arsize),
		.o_m_arburst(m_arburst),
		.i_m_bvalid (m_bvalid),
		.o_m_bready (m_bready),
		.i_m_bresp  (m_bresp),
		.o_bvalid   (l_bvalid),
		.i_bready   (l_bready),
		.o_bresp    (l_bresp),
		.i_m_rvalid (m_rvalid),
		.o_m_rready (m_rready),
		.i_m_rdata  (m_rdata),
		.i_m_rresp  (m_rresp),
		.o_rvalid   (l_rvalid),
		.i_rready   (l_rready),
		.o_rdata    (l_rdata),
		.o_rresp    (l_rresp)
	);

	// Response IDs go unused, since only one ID is ever in flight per side
	axi_sram #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.ID_WIDTH  (ID_WIDTH),
		.LGMEM     (LGMEM)
	) u_sram (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_awvalid(m_awvalid),
		.o_awready(m_awready),
		.i_awid   (m_awid),
		.i_awaddr (m_awaddr),
		.i_awlen  (m_awlen),
		.i_awsize (m_awsize),
		.i_awburst(m_awburst),
		.i_wvalid (m_wvalid),
		.o_wready (m_wready),
		.i_wdata  (m_wdata),
		.i_wstrb  (m_wstrb),
		.i_wlast  (m_wlast),
		.o_bvalid (m_bvalid),
		.i_bready (m_bready),
		.o_bid    (),
		.o_bresp  (m_bresp),
		.i_arvalid(m_arvalid),
		.o_arready(m_arready),
		.i_arid   (m_arid),
		.i_araddr (m_araddr),
		.i_arlen  (m_arlen),
		.i_arsize (m_arsize),
		.i_arburst(m_arburst),
		.o_rvalid (m_rvalid),
		.i_rready (m_rready),
		.o_rid    (),
		.o_rdata  (m_rdata),
		.o_rresp  (m_rresp)
	);

endmodule

/* hw/axi_sram.sv */
// Single-beat AXI memory slave with byte strobes, DECERR past its size and SLVERR on bursts
`timescale 1ns/100ps

module axi_sram
	import wb_axi_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4,
	parameter int LGMEM      = 8
) (
	input  logic                    i_clk,
	input  logic                    i_reset,
	// Write address
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [ID_WIDTH-1:0]     i_awid,
	input  logic [ADDR_WIDTH-1:0]   i_awaddr,
	input  logic [7:0]              i_awlen,
	input  logic [2:0]              i_awsize,
	input  logic [1:0]              i_awburst,
	// Write data
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [DATA_WIDTH-1:0]   i_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_wstrb,
	input  logic                    i_wlast,
	// Write response
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [ID_WIDTH-1:0]     o_bid,
	output logic [1:0]              o_bresp,
	// Read address
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [ID_WIDTH-1:0]     i_arid,
	input  logic [ADDR_WIDTH-1:0]   i_araddr,
	input  logic [7:0]              i_arlen,
	input  logic [2:0]              i_arsize,
	input  logic [1:0]              i_arburst,
	// Read data
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [ID_WIDTH-1:0]     o_rid,
	output logic [DATA_WIDTH-1:0]   o_rdata,
	output logic [1:0]              o_rresp
);

	localparam int LSB   = $clog2(DATA_WIDTH/8);
	localparam int WORDS = 1 << LGMEM;

	logic [DATA_WIDTH-1:0] mem [0:WORDS-1];

	logic             wr_fire;
	logic             wr_decerr;
	logic             wr_bad;
	logic [LGMEM-1:0] wr_index;
	logic             rd_fire;
	logic             rd_decerr;
	logic             rd_bad;
	logic [LGMEM-1:0] rd_index;

	////////////////////
	// Write side
	////////////////////

	// AW and W are taken in the same cycle, only once B is free
	assign o_awready = i_wvalid && (!o_bvalid || i_bready);
	assign o_wready  = i_awvalid && (!o_bvalid || i_bready);
	assign wr_fire   = i_awvalid && o_awready;

	// Any address bit above the array means no memory there
	assign wr_decerr = |i_awaddr[ADDR_WIDTH-1:LGMEM+LSB];
	// Only single full-width INCR beats are served
	assign wr_bad = (i_awlen != AXI_LEN_SINGLE) || (i_awburst != AXI_BURST_INCR)
		|| (i_awsize != 3'(LSB)) || !i_wlast;
	assign wr_index = i_awaddr[LSB +: LGMEM];

	// Byte lanes written only where the strobe is set
	always_ff @(posedge i_clk)
		if (wr_fire && !wr_decerr && !wr_bad)
			for (int b = 0; b < DATA_WIDTH/8; b++)
				if (i_wstrb[b])
					mem[wr_index][b*8 +: 8] <= i_wdata[b*8 +: 8];

	always_ff @(posedge i_clk)
		if (i_reset)
			o_bvalid <= 1'b0;
		else if (wr_fire)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;

	// Decode error wins over a malformed burst
	always_ff @(posedge i_clk)
		if (wr_fire)
		begin
			o_bid <= i_awid;
			if (wr_decerr)
				o_bresp <= AXI_RESP_DECERR;
			else if (wr_bad)
				o_bresp <= AXI_RESP_SLVERR;
			else
				o_bresp <= AXI_RESP_OKAY;
		end

	////////////////////
	// Read side
	////////////////////

	// New address held off while R waits on ready
	assign o_arready = !o_rvalid || i_rready;
	assign rd_fire   = i_arvalid && o_arready;
	assign rd_decerr = |i_araddr[ADDR_WIDTH-1:LGMEM+LSB];
	assign rd_bad    = (i_arlen != AXI_LEN_SINGLE) || (i_arburst != AXI_BURST_INCR)
		|| (i_arsize != 3'(LSB));
	assign rd_index  = i_araddr[LSB +: LGMEM];

	always_ff @(posedge i_clk)
		if (i_reset)
			o_rvalid <= 1'b0;
		else if (rd_fire)
			o_rvalid <= 1'b1;
		else if (i_rready)
			o_rvalid <= 1'b0;

	// Failed reads return zero data
	always_ff @(posedge i_clk)
		if (rd_fire)
		begin
			o_rid <= i_arid;
			if (rd_decerr)
			begin
				o_rdata <= '0;
				o_rresp <= AXI_RESP_DECERR;
			end
			else if (rd_bad)
			begin
				o_rdata <= '0;
				o_rresp <= AXI_RESP_SLVERR;
			end
			else
			begin
				o_rdata <= mem[rd_index];
				o_rresp <= AXI_RESP_OKAY;
			end
		end

endmodule

/* hw/axil_to_axi.sv */
// AXI-lite to full AXI adapter with one-deep request slices and fixed single-beat burst fields
`timescale 1ns/100ps

module axil_to_axi
	import wb_axi_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4
) (
	input  logic                    i_clk,
	input  logic                    i_reset,
	// AXI-lite requests from control
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [ADDR_WIDTH-1:0]   i_awaddr,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [DATA_WIDTH-1:0]   i_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_wstrb,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [ADDR_WIDTH-1:0]   i_araddr,
	// AXI write address
	output logic                    o_m_awvalid,
	input  logic                    i_m_awready,
	output logic [ID_WIDTH-1:0]     o_m_awid,
	output logic [ADDR_WIDTH-1:0]   o_m_awaddr,
	output logic [7:0]              o_m_awlen,
	output logic [2:0]              o_m_awsize,
	output logic [1:0]              o_m_awburst,
	// AXI write data
	output logic                    o_m_wvalid,
	input  logic                    i_m_wready,
	output logic [DATA_WIDTH-1:0]   o_m_wdata,
	output logic [DATA_WIDTH/8-1:0] o_m_wstrb,
	output logic                    o_m_wlast,
	// AXI read address
	output logic                    o_m_arvalid,
	input  logic                    i_m_arready,
	output logic [ID_WIDTH-1:0]     o_m_arid,
	output logic [ADDR_WIDTH-1:0]   o_m_araddr,
	output logic [7:0]              o_m_arlen,
	output logic [2:0]              o_m_arsize,
	output logic [1:0]              o_m_arburst,
	// Write response
	input  logic                    i_m_bvalid,
	output logic                    o_m_bready,
	input  logic [1:0]              i_m_bresp,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [1:0]              o_bresp,
	// Read response
	input  logic                    i_m_rvalid,
	output logic                    o_m_rready,
	input  logic [DATA_WIDTH-1:0]   i_m_rdata,
	input  logic [1:0]              i_m_rresp,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [DATA_WIDTH-1:0]   o_rdata,
	output logic [1:0]              o_rresp
);

	// Reads and writes carry distinct fixed IDs
	localparam logic [ID_WIDTH-1:0] WRITE_ID = '0;
	localparam logic [ID_WIDTH-1:0] READ_ID  = ID_WIDTH'(1);
	// Full-width beats
	localparam logic [2:0] BEAT_SIZE = 3'($clog2(DATA_WIDTH/8));

	////////////////////
	// Request slices
	////////////////////

	// Each slice takes a new entry when empty or emptying this cycle
	assign o_awready = !o_m_awvalid || i_m_awready;
	assign o_wready  = !o_m_wvalid || i_m_wready;
	assign o_arready = !o_m_arvalid || i_m_arready;

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_m_awvalid <= 1'b0;
			o_m_wvalid  <= 1'b0;
			o_m_arvalid <= 1'b0;
		end
		else
		begin
			if (o_awready)
				o_m_awvalid <= i_awvalid;
			if (o_wready)
				o_m_wvalid <= i_wvalid;
			if (o_arready)
				o_m_arvalid <= i_arvalid;
		end

	// Payloads follow their own slice's ready
	always_ff @(posedge i_clk)
	begin
		if (o_awready)
			o_m_awaddr <= i_awaddr;
		if (o_wready)
		begin
			o_m_wdata <= i_wdata;
			o_m_wstrb <= i_wstrb;
		end
		if (o_arready)
			o_m_araddr <= i_araddr;
	end

	// Fixed burst fields, one beat of full width
	assign o_m_awid    = WRITE_ID;
	assign o_m_awlen   = AXI_LEN_SINGLE;
	assign o_m_awsize  = BEAT_SIZE;
	assign o_m_awburst = AXI_BURST_INCR;
	assign o_m_wlast   = 1'b1;
	assign o_m_arid    = READ_ID;
	assign o_m_arlen   = AXI_LEN_SINGLE;
	assign o_m_arsize  = BEAT_SIZE;
	assign o_m_arburst = AXI_BURST_INCR;

	////////////////////
	// Responses
	////////////////////

	// Straight through, no added latency
	assign o_bvalid   = i_m_bvalid;
	assign o_bresp    = i_m_bresp;
	assign o_m_bready = i_bready;
	assign o_rvalid   = i_m_rvalid;
	assign o_rdata    = i_m_rdata;
	assign o_rresp    = i_m_rresp;
	assign o_m_rready = i_rready;

endmodule

/* hw/wb_to_axil.sv */
// Control block turning pipelined Wishbone requests into AXI-lite transactions with ack/err return
`timescale 1ns/100ps

module wb_to_axil
	import wb_axi_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int LGFIFO     = 3
) (
	input  logic                                     i_clk,
	input  logic                                     i_reset,
	// Wishbone pipelined slave
	input  logic                                     i_wb_cyc,
	input  logic                                     i_wb_stb,
	input  logic                                     i_wb_we,
	input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0] i_wb_addr,
	input  logic [DATA_WIDTH-1:0]                    i_wb_data,
	input  logic [DATA_WIDTH/8-1:0]                  i_wb_sel,
	output logic                                     o_wb_stall,
	output logic                                     o_wb_ack,
	output logic                                     o_wb_err,
	output logic [DATA_WIDTH-1:0]                    o_wb_data,
	// AXI-lite write request
	output logic                                     o_awvalid,
	input  logic                                     i_awready,
	output logic [ADDR_WIDTH-1:0]                    o_awaddr,
	output logic                                     o_wvalid,
	input  logic                                     i_wready,
	output logic [DATA_WIDTH-1:0]                    o_wdata,
	output logic [DATA_WIDTH/8-1:0]                  o_wstrb,
	// AXI-lite write response
	input  logic                                     i_bvalid,
	output logic                                     o_bready,
	input  logic [1:0]                               i_bresp,
	// AXI-lite read request
	output logic                                     o_arvalid,
	input  logic                                     i_arready,
	output logic [ADDR_WIDTH-1:0]                    o_araddr,
	// AXI-lite read response
	input  logic                                     i_rvalid,
	output logic                                     o_rready,
	input  logic [DATA_WIDTH-1:0]                    i_rdata,
	input  logic [1:0]                               i_rresp
);

	// Low byte-address bits below the Wishbone word address
	localparam int WBLSB = $clog2(DATA_WIDTH/8);

	logic                  accept;
	logic                  resp;
	logic                  full;
	logic                  dir_conflict;
	logic                  req_busy;
	logic                  r_we;
	logic [LGFIFO:0]       npending;
	logic [ADDR_WIDTH-1:0] r_addr;

	////////////////////
	// Request side
	////////////////////

	// Responses are always taken, since ack and err are registered
	assign o_bready = 1'b1;
	assign o_rready = 1'b1;

	// Outstanding count at its limit
	assign full = (npending == (LGFIFO+1)'(1 << LGFIFO));
	// Reads and writes never mix while anything is outstanding
	assign dir_conflict = (npending != '0) && (i_wb_we != r_we);
	// A request still held on a channel that will not transfer now
	assign req_busy = (o_awvalid && !i_awready) || (o_wvalid && !i_wready)
		|| (o_arvalid && !i_arready);

	assign o_wb_stall = full || dir_conflict || req_busy;
	assign accept = i_wb_cyc && i_wb_stb && !o_wb_stall;

	// A response of either kind retires one transaction
	assign resp = (i_bvalid && o_bready) || (i_rvalid && o_rready);

	// Direction of whatever is outstanding
	always_ff @(posedge i_clk)
		if (i_reset)
			r_we <= 1'b0;
		else if (accept)
			r_we <= i_wb_we;

	// Count up on acceptance, down on response
	always_ff @(posedge i_clk)
		if (i_reset)
			npending <= '0;
		else
		begin
			case ({accept, resp})
				2'b10: npending <= npending + 1'b1;
				2'b01: npending <= npending - 1'b1;
				default: npending <= npending;
			endcase
		end

	// AW and W go out together the cycle after a write is accepted
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
			o_arvalid <= 1'b0;
		end
		else
		begin
			if (accept && i_wb_we)
				o_awvalid <= 1'b1;
			else if (i_awready)
				o_awvalid <= 1'b0;

			if (accept && i_wb_we)
				o_wvalid <= 1'b1;
			else if (i_wready)
				o_wvalid <= 1'b0;

			if (accept && !i_wb_we)
				o_arvalid <= 1'b1;
			else if (i_arready)
				o_arvalid <= 1'b0;
		end

	// Payload only loads on acceptance, which the stall keeps away from held valids
	always_ff @(posedge i_clk)
		if (accept)
		begin
			r_addr  <= {i_wb_addr, {WBLSB{1'b0}}};
			o_wdata <= i_wb_data;
			o_wstrb <= i_wb_sel;
		end

	// One address register serves both sides, as directions never overlap
	assign o_awaddr = r_addr;
	assign o_araddr = r_addr;

	////////////////////
	// Response side
	////////////////////

	// Any non-OKAY response becomes a bus error
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end
		else
		begin
			o_wb_ack <= (i_bvalid && (i_bresp == AXI_RESP_OKAY))
				|| (i_rvalid && (i_rresp == AXI_RESP_OKAY));
			o_wb_err <= (i_bvalid && (i_bresp != AXI_RESP_OKAY))
				|| (i_rvalid && (i_rresp != AXI_RESP_OKAY));
		end

	// Read data lines up with the ack of the same cycle
	always_ff @(posedge i_clk)
		if (i_rvalid)
			o_wb_data <= i_rdata;

endmodule

/* hw/wb_axi_pkg.sv */
// Shared AXI response codes and fixed burst fields, imported by every bridge RTL module
package wb_axi_pkg;

	////////////////////
	// AXI response codes
	////////////////////

	// Normal completion
	parameter logic [1:0] AXI_RESP_OKAY   = 2'b00;
	// Slave saw the request but could not complete it
	parameter logic [1:0] AXI_RESP_SLVERR = 2'b10;
	// No slave at this address
	parameter logic [1:0] AXI_RESP_DECERR = 2'b11;

	////////////////////
	// Burst fields
	////////////////////

	// Incrementing burst type, the only one issued here
	parameter logic [1:0] AXI_BURST_INCR = 2'b01;
	// AxLEN is beats minus one, so zero means a single beat
	parameter logic [7:0] AXI_LEN_SINGLE = 8'd0;

endpackage
